// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_leaf_i4o1
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: leaf_i4o1.sv
module leaf_i4o1 (
    input  logic              clk_400,
    input  logic              rst_n,
    input  leaf_pkg::packet_u din,
    output leaf_pkg::packet_u dout,
    input  logic              resend,
    input  logic              ap_start
);
    import leaf_pkg::*;

    user_link_t [NUM_IN_PORTS-1:0] links;
    logic [NUM_IN_PORTS-1:0]       acks;
    user_link_t                    user_out;
    logic                          user_ack;
    logic                          user_rst_n;

    leaf_interface leaf_interface_inst (
        .clk_400    (clk_400),
        .rst_n      (rst_n),
        .din        (din),
        .dout       (dout),
        .resend     (resend),
        .ap_start   (ap_start),
        .user_rst_n (user_rst_n),
        .links      (links),
        .acks       (acks),
        .user_out   (user_out),
        .user_ack   (user_ack)
    );

    user_kernel user_kernel_inst (
        .clk_400    (clk_400),
        .user_rst_n (user_rst_n),
        .links      (links),
        .acks       (acks),
        .user_out   (user_out),
        .user_ack   (user_ack)
    );

endmodule

// File: leaf_interface.sv
module leaf_interface (
    input  logic                                              clk_400,
    input  logic                                              rst_n,
    input  leaf_pkg::packet_u                                 din,
    output leaf_pkg::packet_u                                 dout,
    input  logic                                              resend,
    input  logic                                              ap_start,
    output logic                                              user_rst_n,
    output leaf_pkg::user_link_t [leaf_pkg::NUM_IN_PORTS-1:0] links,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]                 acks,
    input  leaf_pkg::user_link_t                              user_out,
    output logic                                              user_ack
);
    import leaf_pkg::*;

    logic [NUM_IN_PORTS-1:0] full;
    logic [NUM_IN_PORTS-1:0] wr_en;
    word_t                   wr_data;
    dest_t                   dest;

    // kernel stays in reset until the host starts it.
    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            user_rst_n <= 1'b0;
        end else if (ap_start) begin
            user_rst_n <= 1'b1;
        end
    end

    leaf_rx rx_inst (
        .clk_400 (clk_400),
        .rst_n   (rst_n),
        .din     (din),
        .full    (full),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .dest    (dest)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_port
        port_fifo fifo_inst (
            .clk_400 (clk_400),
            .rst_n   (rst_n),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data),
            .link    (links[i]),
            .ack     (acks[i]),
            .full    (full[i])
        );
    end

    leaf_tx tx_inst (
        .clk_400  (clk_400),
        .rst_n    (rst_n),
        .resend   (resend),
        .dest     (dest),
        .user_out (user_out),
        .ack      (user_ack),
        .dout     (dout)
    );

endmodule

// File: leaf_pkg.sv
package leaf_pkg;

    ////////////////////////////////////////////////////////////
    // network constants
    ////////////////////////////////////////////////////////////

    localparam int unsigned PACKET_BITS   = 49;
    localparam int unsigned PAYLOAD_BITS  = 32;
    localparam int unsigned NUM_LEAF_BITS = 5;
    localparam int unsigned NUM_PORT_BITS = 4;
    localparam int unsigned NUM_IN_PORTS  = 4;
    localparam int unsigned FIFO_DEPTH    = 8;
    localparam int unsigned FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_BITS = FIFO_PTR_BITS + 1;

    // what is left of a data packet after address and payload.
    localparam int unsigned TAG_BITS    = PACKET_BITS - 1 - NUM_LEAF_BITS - NUM_PORT_BITS
                                          - PAYLOAD_BITS;
    localparam int unsigned OPCODE_BITS = 7;
    localparam int unsigned RSVD_BITS   = PACKET_BITS - 1 - 2 * NUM_LEAF_BITS
                                          - 2 * NUM_PORT_BITS - OPCODE_BITS;

    localparam logic [NUM_LEAF_BITS-1:0] MY_LEAF  = 5'd3;
    localparam logic [NUM_PORT_BITS-1:0] CFG_PORT = 4'd0;

    ////////////////////////////////////////////////////////////
    // packet and link types
    ////////////////////////////////////////////////////////////

    typedef logic [PAYLOAD_BITS-1:0] word_t;

    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [TAG_BITS-1:0]      tag;
        word_t                    payload;
    } data_pkt_t;

    // same word seen by the configuration decoder.
    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [OPCODE_BITS-1:0]   opcode;
        logic [NUM_LEAF_BITS-1:0] ret_leaf;
        logic [NUM_PORT_BITS-1:0] ret_port;
        logic [RSVD_BITS-1:0]     rsvd;
    } cfg_pkt_t;

    typedef union packed {
        data_pkt_t data;
        cfg_pkt_t  cfg;
    } packet_u;

    typedef struct packed {
        logic  valid;
        word_t data;
    } user_link_t;

    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
    } dest_t;

endpackage

// File: leaf_rx.sv
module leaf_rx (
    input  logic                              clk_400,
    input  logic                              rst_n,
    input  leaf_pkg::packet_u                 din,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0] full,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0] wr_en,
    output leaf_pkg::word_t                   wr_data,
    output leaf_pkg::dest_t                   dest
);
    import leaf_pkg::*;

    logic hit;
    logic is_cfg;

    // valid bit and leaf field sit in the same place in both views.
    assign hit    = din.data.valid && (din.data.leaf == MY_LEAF);
    assign is_cfg = hit && (din.cfg.port == CFG_PORT);

    assign wr_data = din.data.payload;

    // port n goes to queue n-1 and other port numbers fall through.
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            wr_en[i] = hit && (din.data.port == NUM_PORT_BITS'(i + 1)) && !full[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // return address of the kernel results
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            dest <= '0;
        end else if (is_cfg) begin
            dest.leaf <= din.cfg.ret_leaf;
            dest.port <= din.cfg.ret_port;
        end
    end

endmodule

// File: leaf_tx.sv
module leaf_tx (
    input  logic                 clk_400,
    input  logic                 rst_n,
    input  logic                 resend,
    input  leaf_pkg::dest_t      dest,
    input  leaf_pkg::user_link_t user_out,
    output logic                 ack,
    output leaf_pkg::packet_u    dout
);
    import leaf_pkg::*;

    packet_u             pkt_r;
    logic [TAG_BITS-1:0] seq;

    // no handshake toward the kernel while resend is up.
    assign ack = user_out.valid && !resend;

    assign dout = resend ? packet_u'('0) : pkt_r;

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            pkt_r <= '0;
            seq   <= '0;
        end else begin
            // a packet is on the tree for one cycle only.
            pkt_r <= '0;
            if (ack) begin
                pkt_r.data.valid   <= 1'b1;
                pkt_r.data.leaf    <= dest.leaf;
                pkt_r.data.port    <= dest.port;
                pkt_r.data.tag     <= seq;
                pkt_r.data.payload <= user_out.data;
                seq                <= seq + 1'b1;
            end
        end
    end

endmodule

// File: port_fifo.sv
module port_fifo (
    input  logic                 clk_400,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  leaf_pkg::word_t      wr_data,
    output leaf_pkg::user_link_t link,
    input  logic                 ack,
    output logic                 full
);
    import leaf_pkg::*;

    word_t                    mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic [FIFO_CNT_BITS-1:0] count;
    logic                     push;
    logic                     pop;

    assign full = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
    assign push = wr_en && !full;
    assign pop  = ack && link.valid;

    // head of the queue goes straight to the kernel.
    assign link.valid = (count != '0);
    assign link.data  = mem[rd_ptr];

    always_ff @(posedge clk_400) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: src.f
leaf_pkg.sv
port_fifo.sv
leaf_rx.sv
leaf_tx.sv
leaf_interface.sv
user_kernel.sv
leaf_i4o1.sv
tb_leaf_i4o1.sv

// File: tb_leaf_i4o1.sv
module tb_leaf_i4o1;
    import leaf_pkg::*;

    typedef word_t [NUM_IN_PORTS-1:0] word_set_t;

    localparam int RESULT_WAIT = 400;
    localparam int BURST_SETS  = FIFO_DEPTH;

    logic    clk_400;
    logic    rst_n;
    packet_u din;
    packet_u dout;
    logic    resend;
    logic    ap_start;

    // expected packets on dout in arrival order.
    packet_u             exp_q[$];
    packet_u             mon_exp;
    dest_t               cur_dest;
    logic [TAG_BITS-1:0] exp_tag;
    int                  sent_count;

    leaf_i4o1 i_dut (
        .clk_400  (clk_400),
        .rst_n    (rst_n),
        .din      (din),
        .dout     (dout),
        .resend   (resend),
        .ap_start (ap_start)
    );

    initial begin
        clk_400 = 1'b0;
        forever #4 clk_400 = ~clk_400;
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_packet(input packet_u got, input packet_u exp, input string what);
        dest_t got_dest;
        dest_t exp_dest;
        got_dest.leaf = got.data.leaf;
        got_dest.port = got.data.port;
        exp_dest.leaf = exp.data.leaf;
        exp_dest.port = exp.data.port;
        if (got.data.valid !== exp.data.valid) begin
            stop_run($sformatf("ERROR at %0t: %s valid bit %b, expected %b",
                               $time, what, got.data.valid, exp.data.valid));
        end else if (got_dest !== exp_dest) begin
            stop_run($sformatf("ERROR at %0t: %s sent to leaf %0d port %0d, expected %0d/%0d",
                               $time, what, got_dest.leaf, got_dest.port,
                               exp_dest.leaf, exp_dest.port));
        end else if (got.data.payload !== exp.data.payload) begin
            stop_run($sformatf("ERROR at %0t: %s payload %h, expected %h",
                               $time, what, got.data.payload, exp.data.payload));
        end else if (got !== exp) begin
            stop_run($sformatf("ERROR at %0t: %s packet %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    // every result on the tree is matched against the model in order.
    always @(negedge clk_400) begin
        if (rst_n === 1'b1) begin
            if (dout.data.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_run($sformatf("ERROR at %0t: unexpected packet %h on dout",
                                       $time, dout));
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_packet(dout, mon_exp, "result packet");
                end
            end else begin
                check_packet(dout, packet_u'('0), "idle dout");
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk_400);
            cycles++;
            if (cycles > sent_count * 64 + 2000) begin
                stop_run($sformatf("timeout: run still going after %0d cycles, %0d packets sent",
                                   cycles, sent_count));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // packet helpers and model
    ////////////////////////////////////////////////////////////

    function automatic packet_u data_packet(input logic [NUM_LEAF_BITS-1:0] leaf,
                                            input logic [NUM_PORT_BITS-1:0] port,
                                            input word_t payload);
        packet_u p;
        p = '0;
        p.data.valid   = 1'b1;
        p.data.leaf    = leaf;
        p.data.port    = port;
        p.data.payload = payload;
        return p;
    endfunction

    function automatic packet_u cfg_packet(input logic [NUM_LEAF_BITS-1:0] leaf,
                                           input dest_t ret);
        packet_u p;
        p = '0;
        p.cfg.valid    = 1'b1;
        p.cfg.leaf     = leaf;
        p.cfg.port     = CFG_PORT;
        p.cfg.opcode   = 7'h01;
        p.cfg.ret_leaf = ret.leaf;
        p.cfg.ret_port = ret.port;
        return p;
    endfunction

    function automatic word_set_t random_set();
        word_set_t w;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            w[i] = $urandom();
        end
        return w;
    endfunction

    // the sum of the four words wraps at 32 bits.
    function automatic word_t set_sum(input word_set_t w);
        word_t s;
        s = '0;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            s = s + w[i];
        end
        return s;
    endfunction

    task automatic expect_result(input word_t sum);
        packet_u p;
        p = '0;
        p.data.valid   = 1'b1;
        p.data.leaf    = cur_dest.leaf;
        p.data.port    = cur_dest.port;
        p.data.tag     = exp_tag;
        p.data.payload = sum;
        exp_q.push_back(p);
        exp_tag = exp_tag + 1'b1;
    endtask

    task automatic send_packet(input packet_u p);
        @(posedge clk_400);
        din <= p;
        sent_count++;
        if (p.cfg.valid && p.cfg.leaf == MY_LEAF && p.cfg.port == CFG_PORT) begin
            cur_dest.leaf = p.cfg.ret_leaf;
            cur_dest.port = p.cfg.ret_port;
        end
    endtask

    // mask bit i sends w[i] to port i+1.
    task automatic send_ports(input word_set_t w, input logic [NUM_IN_PORTS-1:0] mask);
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            if (mask[i]) begin
                send_packet(data_packet(MY_LEAF, NUM_PORT_BITS'(i + 1), w[i]));
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_400);
            din <= '0;
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_400);
            din <= '0;
            waited++;
            if (waited > RESULT_WAIT) begin
                stop_run($sformatf("timeout: %0d result packets never appeared", exp_q.size()));
            end
        end
        // a few quiet cycles so that a stray extra packet is caught.
        idle(10);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic start_gate();
        word_set_t w;
        w = random_set();
        send_ports(w, 4'hf);
        idle(1);
        repeat (20) begin
            @(negedge clk_400);
            check_packet(dout, packet_u'('0), "dout before start");
        end
        @(posedge clk_400);
        ap_start <= 1'b1;
        @(posedge clk_400);
        ap_start <= 1'b0;
        expect_result(set_sum(w));
        wait_results();
    endtask

    task automatic config_dest();
        dest_t     d;
        word_set_t w;
        d.leaf = 5'd17;
        d.port = 4'd9;
        send_packet(cfg_packet(MY_LEAF, d));
        w = random_set();
        expect_result(set_sum(w));
        send_ports(w, 4'hf);
        wait_results();
        d.leaf = NUM_LEAF_BITS'($urandom_range(31, 0));
        d.port = NUM_PORT_BITS'($urandom_range(15, 0));
        send_packet(cfg_packet(MY_LEAF, d));
        repeat (2) begin
            w = random_set();
            expect_result(set_sum(w));
            send_ports(w, 4'hf);
        end
        wait_results();
    endtask

    task automatic address_filter();
        packet_u   p;
        word_set_t w;
        dest_t     d;
        send_packet(data_packet(MY_LEAF + 5'd1, 4'd1, $urandom()));
        p = data_packet(MY_LEAF, 4'd2, $urandom());
        p.data.valid = 1'b0;
        send_packet(p);
        send_packet(data_packet(MY_LEAF, 4'd5, $urandom()));
        send_packet(data_packet(MY_LEAF, 4'd15, $urandom()));
        d.leaf = 5'd30;
        d.port = 4'd14;
        send_packet(cfg_packet(MY_LEAF + 5'd1, d));
        repeat (2) begin
            w = random_set();
            expect_result(set_sum(w));
            send_ports(w, 4'hf);
        end
        wait_results();
    endtask

    task automatic queue_overflow();
        word_t     first;
        word_t     burst [FIFO_DEPTH+1];
        word_set_t w;
        // the kernel holds this word, so port 1 queue stays undrained.
        first = $urandom();
        send_packet(data_packet(MY_LEAF, 4'd1, first));
        idle(6);
        for (int i = 0; i < int'(FIFO_DEPTH) + 1; i++) begin
            burst[i] = $urandom();
            send_packet(data_packet(MY_LEAF, 4'd1, burst[i]));
        end
        w = random_set();
        w[0] = first;
        expect_result(set_sum(w));
        send_ports(w, 4'b1110);
        wait_results();
        for (int k = 0; k < int'(FIFO_DEPTH); k++) begin
            w = random_set();
            w[0] = burst[k];
            expect_result(set_sum(w));
            send_ports(w, 4'b1110);
        end
        wait_results();
        // the ninth burst word was dropped, so a fresh port 1 word is used.
        w = random_set();
        expect_result(set_sum(w));
        send_ports(w, 4'hf);
        wait_results();
    endtask

    task automatic resend_stall();
        word_set_t w;
        @(posedge clk_400);
        resend <= 1'b1;
        w = random_set();
        send_ports(w, 4'hf);
        idle(1);
        repeat (40) begin
            @(negedge clk_400);
            check_packet(dout, packet_u'('0), "dout under resend");
        end
        @(posedge clk_400);
        resend <= 1'b0;
        expect_result(set_sum(w));
        wait_results();
    endtask

    task automatic random_burst();
        word_set_t sets [BURST_SETS];
        int        order [NUM_IN_PORTS];
        int        pick;
        int        tmp;
        for (int s = 0; s < BURST_SETS; s++) begin
            sets[s] = random_set();
            expect_result(set_sum(sets[s]));
        end
        for (int s = 0; s < BURST_SETS; s++) begin
            for (int j = 0; j < NUM_IN_PORTS; j++) begin
                order[j] = j;
            end
            for (int j = NUM_IN_PORTS - 1; j > 0; j--) begin
                pick = $urandom_range(j, 0);
                tmp = order[j];
                order[j] = order[pick];
                order[pick] = tmp;
            end
            for (int j = 0; j < NUM_IN_PORTS; j++) begin
                send_packet(data_packet(MY_LEAF, NUM_PORT_BITS'(order[j] + 1),
                                        sets[s][order[j]]));
                if ($urandom_range(3, 0) == 0) begin
                    idle(1);
                end
            end
        end
        wait_results();
    endtask

    initial begin
        void'($urandom(88));
        rst_n      <= 1'b0;
        din        <= '0;
        resend     <= 1'b0;
        ap_start   <= 1'b0;
        cur_dest   = '0;
        exp_tag    = '0;
        sent_count = 0;
        repeat (8) @(posedge clk_400);
        rst_n <= 1'b1;
        idle(2);
        start_gate();
        config_dest();
        address_filter();
        queue_overflow();
        resend_stall();
        random_burst();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: user_kernel.sv
module user_kernel (
    input  logic                                              clk_400,
    input  logic                                              user_rst_n,
    input  leaf_pkg::user_link_t [leaf_pkg::NUM_IN_PORTS-1:0] links,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                 acks,
    output leaf_pkg::user_link_t                              user_out,
    input  logic                                              user_ack
);
    import leaf_pkg::*;

    logic [NUM_IN_PORTS-1:0] taken;
    logic [NUM_IN_PORTS-1:0] ack_r;
    word_t                   acc;
    word_t                   acc_next;
    logic                    out_valid;

    assign acks = ack_r;

    assign user_out.valid = out_valid;
    assign user_out.data  = acc;

    // words popped at this edge join the running sum.
    always_comb begin
        acc_next = acc;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            if (ack_r[i]) begin
                acc_next = acc_next + links[i].data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // collect one word per port, then hand out the sum
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_400) begin
        if (!user_rst_n) begin
            taken     <= '0;
            ack_r     <= '0;
            acc       <= '0;
            out_valid <= 1'b0;
        end else begin
            // one-cycle ack pulse per word still missing from the set.
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                ack_r[i] <= links[i].valid && !taken[i] && !ack_r[i];
            end

            if (user_ack) begin
                taken     <= '0;
                acc       <= '0;
                out_valid <= 1'b0;
            end else begin
                taken <= taken | ack_r;
                acc   <= acc_next;
                if (&taken && !out_valid) begin
                    out_valid <= 1'b1;
                end
            end
        end
    end

endmodule
